//--- Makefile
VERILATOR  ?= verilator
TOP        := vga_tb
FILELIST   := files.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
src/vga_pkg.sv
src/draw_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/frame_ctrl.sv
src/draw_bg.sv
src/draw_rect.sv
src/vga_top.sv
testbench/vga_tb.sv

//--- src/draw_bg.sv
// draw_bg
// Background painter. White one-pixel border, navy upper half, dark green
// lower half and black in blanking. One cycle of latency.

`timescale 1ns/10ps

module draw_bg import vga_pkg::*, draw_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.in    bg_in,
  vga_if.out   bg_out
);

  rgb_t rgb_nxt;
  logic border;

  assign border = (bg_in.hcount == '0) || (bg_in.hcount == HBLKSTART - 11'd1) ||
                  (bg_in.vcount == '0) || (bg_in.vcount == VBLKSTART - 11'd1);

  always_comb begin
    if (bg_in.hblnk || bg_in.vblnk) begin
      rgb_nxt = COLOR_BLANK;
    end else if (border) begin
      rgb_nxt = COLOR_BORDER;
    end else if (bg_in.vcount < (VBLKSTART >> 1)) begin
      rgb_nxt = COLOR_TOP;     // upper half.
    end else begin
      rgb_nxt = COLOR_BOTTOM;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bg_out.hcount <= '0;
      bg_out.vcount <= '0;
      bg_out.hsync  <= 1'b0;
      bg_out.vsync  <= 1'b0;
      bg_out.hblnk  <= 1'b0;
      bg_out.vblnk  <= 1'b0;
      bg_out.rgb    <= COLOR_BLANK;
    end else begin
      bg_out.hcount <= bg_in.hcount;
      bg_out.vcount <= bg_in.vcount;
      bg_out.hsync  <= bg_in.hsync;
      bg_out.vsync  <= bg_in.vsync;
      bg_out.hblnk  <= bg_in.hblnk;
      bg_out.vblnk  <= bg_in.vblnk;
      bg_out.rgb    <= rgb_nxt;
    end
  end

endmodule

//--- src/draw_pkg.sv
// draw_pkg
// Rectangle size, palette and control FSM states for the drawing stages.

package draw_pkg;

  import vga_pkg::*;

  // rectangle size in pixels.
  localparam hcount_t RECT_W = 11'd64;
  localparam vcount_t RECT_H = 11'd48;

  // palette.
  localparam rgb_t COLOR_BORDER = 12'hfff;  // white.
  localparam rgb_t COLOR_TOP    = 12'h008;  // navy.
  localparam rgb_t COLOR_BOTTOM = 12'h040;  // dark green.
  localparam rgb_t COLOR_RECT   = 12'hf80;  // orange.
  localparam rgb_t COLOR_BLANK  = 12'h000;

  // frame_ctrl states.
  typedef enum logic {
    WAIT_FRAME,
    SHOW
  } ctrl_state_t;

endpackage

//--- src/draw_rect.sv
// draw_rect
// Overlays a fixed-size orange rectangle on the incoming picture.
// Position and enable come from frame_ctrl. One cycle of latency.

`timescale 1ns/10ps

module draw_rect import vga_pkg::*, draw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  vga_if.in       rect_in,
  vga_if.out      rect_out,
  input  hcount_t rect_x,
  input  vcount_t rect_y,
  input  logic    rect_en
);

  hcount_t dx;
  vcount_t dy;
  logic    in_x;
  logic    in_y;
  logic    hit;
  rgb_t    rgb_nxt;

  // offsets into the rectangle, only meaningful when non-negative.
  assign dx   = rect_in.hcount - rect_x;
  assign dy   = rect_in.vcount - rect_y;
  assign in_x = (rect_in.hcount >= rect_x) && (dx < RECT_W);
  assign in_y = (rect_in.vcount >= rect_y) && (dy < RECT_H);

  // blanking clips anything past the right or bottom edge.
  assign hit = rect_en && !rect_in.hblnk && !rect_in.vblnk && in_x && in_y;

  assign rgb_nxt = hit ? COLOR_RECT : rect_in.rgb;

  always_ff @(posedge clk) begin
    if (rst) begin
      rect_out.hcount <= '0;
      rect_out.vcount <= '0;
      rect_out.hsync  <= 1'b0;
      rect_out.vsync  <= 1'b0;
      rect_out.hblnk  <= 1'b0;
      rect_out.vblnk  <= 1'b0;
      rect_out.rgb    <= COLOR_BLANK;
    end else begin
      rect_out.hcount <= rect_in.hcount;
      rect_out.vcount <= rect_in.vcount;
      rect_out.hsync  <= rect_in.hsync;
      rect_out.vsync  <= rect_in.vsync;
      rect_out.hblnk  <= rect_in.hblnk;
      rect_out.vblnk  <= rect_in.vblnk;
      rect_out.rgb    <= rgb_nxt;
    end
  end

  // holds only if the background stage blacked out blanking as well.
  blank_is_black: assert property (
    @(posedge clk) disable iff (rst)
    (rect_out.hblnk || rect_out.vblnk) |-> (rect_out.rgb == COLOR_BLANK)
  ) else $error("non-black pixel during blanking");

endmodule

//--- src/frame_ctrl.sv
// frame_ctrl
// Keeps the rectangle hidden until the first vertical blanking and loads
// a new position at every start of vertical blanking.

`timescale 1ns/10ps

module frame_ctrl import vga_pkg::*, draw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  vga_if.in       timing_in,
  input  hcount_t xpos,
  input  vcount_t ypos,
  output hcount_t rect_x,
  output vcount_t rect_y,
  output logic    rect_en
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        latch;

  // first pixel of the first blanked line.
  assign latch = (timing_in.hcount == '0) && (timing_in.vcount == VBLKSTART);

  always_comb begin
    state_nxt = state;
    if (state == WAIT_FRAME && latch) begin
      state_nxt = SHOW;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= WAIT_FRAME;
      rect_x <= '0;
      rect_y <= '0;
    end else begin
      state <= state_nxt;
      if (latch) begin
        rect_x <= xpos;  // new frame position.
        rect_y <= ypos;
      end
    end
  end

  assign rect_en = (state == SHOW);

  // a new position shows up right after the rising edge of vblnk.
  rect_x_on_latch: assert property (
    @(posedge clk) disable iff (rst)
    $changed(rect_x) |-> $past(timing_in.vblnk) && !$past(timing_in.vblnk, 2)
  ) else $error("rect_x changed outside the start of vertical blanking");

endmodule

//--- src/vga_if.sv
// vga_if
// Video bus between pipeline stages: counters, syncs, blanking and colour.

`timescale 1ns/10ps

interface vga_if import vga_pkg::*; ();

  hcount_t hcount;
  vcount_t vcount;
  logic    hsync;
  logic    vsync;
  logic    hblnk;
  logic    vblnk;
  rgb_t    rgb;

  // driving stage.
  modport out (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  // receiving stage.
  modport in (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

//--- src/vga_pkg.sv
// vga_pkg
// Video timing constants for 800x600 at 60 Hz with a 40 MHz pixel clock,
// and the counter and colour types shared by all stages.

package vga_pkg;

  // counter and colour types.
  typedef logic [10:0] hcount_t;  // pixel position in a line.
  typedef logic [10:0] vcount_t;  // line position in a frame.
  typedef logic [11:0] rgb_t;     // 4 bits per channel, r in the top nibble.

  // horizontal timing in pixel clocks.
  localparam hcount_t HTOTAL     = 11'd1056;
  localparam hcount_t HBLKSTART  = 11'd800;
  localparam hcount_t HSYNCSTART = 11'd840;
  localparam hcount_t HSYNCTIME  = 11'd128;

  // vertical timing in lines.
  localparam vcount_t VTOTAL     = 11'd628;
  localparam vcount_t VBLKSTART  = 11'd600;
  localparam vcount_t VSYNCSTART = 11'd601;
  localparam vcount_t VSYNCTIME  = 11'd4;

endpackage

//--- src/vga_timing.sv
// vga_timing
// Pixel and line counters for 800x600 with registered sync and blanking.
// Flags are decoded from the next count values so they line up with the
// counts they belong to.

`timescale 1ns/10ps

module vga_timing import vga_pkg::*; (
  input  logic clk,
  input  logic rst,
  vga_if.out   vgat_out
);

  hcount_t hcount_nxt;
  vcount_t vcount_nxt;
  logic    hsync_nxt;
  logic    vsync_nxt;
  logic    hblnk_nxt;
  logic    vblnk_nxt;

  // counter next values.
  always_comb begin
    hcount_nxt = vgat_out.hcount + 11'd1;
    vcount_nxt = vgat_out.vcount;
    if (vgat_out.hcount == HTOTAL - 11'd1) begin
      hcount_nxt = '0;  // end of line.
      if (vgat_out.vcount == VTOTAL - 11'd1) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vgat_out.vcount + 11'd1;
      end
    end
  end

  // vertical flags only move when vcount_nxt does, i.e. on the line wrap.
  always_comb begin
    hblnk_nxt = (hcount_nxt >= HBLKSTART);
    hsync_nxt = (hcount_nxt >= HSYNCSTART) && (hcount_nxt < HSYNCSTART + HSYNCTIME);
    vblnk_nxt = (vcount_nxt >= VBLKSTART);
    vsync_nxt = (vcount_nxt >= VSYNCSTART) && (vcount_nxt < VSYNCSTART + VSYNCTIME);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vgat_out.hcount <= '0;
      vgat_out.vcount <= '0;
      vgat_out.hsync  <= 1'b0;
      vgat_out.vsync  <= 1'b0;
      vgat_out.hblnk  <= 1'b0;
      vgat_out.vblnk  <= 1'b0;
    end else begin
      vgat_out.hcount <= hcount_nxt;
      vgat_out.vcount <= vcount_nxt;
      vgat_out.hsync  <= hsync_nxt;
      vgat_out.vsync  <= vsync_nxt;
      vgat_out.hblnk  <= hblnk_nxt;
      vgat_out.vblnk  <= vblnk_nxt;
    end
  end

  // colour is added downstream.
  assign vgat_out.rgb = '0;

  hcount_in_range: assert property (
    @(posedge clk) disable iff (rst) vgat_out.hcount < HTOTAL
  ) else $error("hcount reached HTOTAL");

endmodule

//--- src/vga_top.sv
// vga_top
// VGA video path. Timing, background, rectangle overlay and the frame
// control that moves the rectangle only between frames.

`timescale 1ns/10ps

module vga_top import vga_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  hcount_t xpos,
  input  vcount_t ypos,
  output hcount_t hcount,
  output vcount_t vcount,
  output logic    hsync,
  output logic    vsync,
  output logic    hblnk,
  output logic    vblnk,
  output rgb_t    rgb
);

  hcount_t rect_x;
  vcount_t rect_y;
  logic    rect_en;

  vga_if timing_if ();  // timing to background.
  vga_if bg_if ();      // background to rectangle.
  vga_if rect_if ();    // rectangle to the pins.

  vga_timing u_vga_timing (
    .clk      (clk),
    .rst      (rst),
    .vgat_out (timing_if.out)
  );

  frame_ctrl u_frame_ctrl (
    .clk       (clk),
    .rst       (rst),
    .timing_in (timing_if.in),
    .xpos      (xpos),
    .ypos      (ypos),
    .rect_x    (rect_x),
    .rect_y    (rect_y),
    .rect_en   (rect_en)
  );

  draw_bg u_draw_bg (
    .clk    (clk),
    .rst    (rst),
    .bg_in  (timing_if.in),
    .bg_out (bg_if.out)
  );

  draw_rect u_draw_rect (
    .clk      (clk),
    .rst      (rst),
    .rect_in  (bg_if.in),
    .rect_out (rect_if.out),
    .rect_x   (rect_x),
    .rect_y   (rect_y),
    .rect_en  (rect_en)
  );

  assign hcount = rect_if.hcount;
  assign vcount = rect_if.vcount;
  assign hsync  = rect_if.hsync;
  assign vsync  = rect_if.vsync;
  assign hblnk  = rect_if.hblnk;
  assign vblnk  = rect_if.vblnk;
  assign rgb    = rect_if.rgb;

endmodule

//--- testbench/vga_tb.sv
// vga_tb
// Testbench for the VGA video path. Random rectangle positions from an LCG,
// a cycle-accurate reference model of counters, flags and colours, and a
// per-cycle compare of every output.

`timescale 1ns/10ps

module vga_tb import vga_pkg::*, draw_pkg::*;;

  localparam int FRAME      = int'(HTOTAL) * int'(VTOTAL);
  localparam int RUN_CYCLES = 2 * FRAME + 1000;
  localparam int TIMEOUT    = 1_990_000;  // about 3 frames.
  localparam int EDGE_X     = 770;        // forced position, clipped on both edges.
  localparam int EDGE_Y     = 570;
  localparam int ORANGE_EXP = (int'(HBLKSTART) - EDGE_X) * (int'(VBLKSTART) - EDGE_Y);

  logic    clk;
  logic    rst;
  hcount_t xpos = '0;
  vcount_t ypos = '0;
  hcount_t hcount;
  vcount_t vcount;
  logic    hsync;
  logic    vsync;
  logic    hblnk;
  logic    vblnk;
  rgb_t    rgb;

  // reference model state.
  hcount_t m_h;
  hcount_t d1_h;
  hcount_t d2_h;
  hcount_t m_rx;
  vcount_t m_v;
  vcount_t d1_v;
  vcount_t d2_v;
  vcount_t m_ry;
  logic    m_en;
  logic    v1;
  rgb_t    exp_rgb;
  int      m_frame = 0;
  int      cycles = 0;
  int      next_change = 1500;
  int      checks = 0;
  int      errors = 0;
  int      orange = 0;
  logic    checking = 1'b0;
  logic [31:0] seed = 32'hdf38;

  vga_top u_vga_top (
    .clk    (clk),
    .rst    (rst),
    .xpos   (xpos),
    .ypos   (ypos),
    .hcount (hcount),
    .vcount (vcount),
    .hsync  (hsync),
    .vsync  (vsync),
    .hblnk  (hblnk),
    .vblnk  (vblnk),
    .rgb    (rgb)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected pixel colour after both drawing stages.
  function automatic rgb_t pixel_colour(input hcount_t h, input vcount_t v,
                                        input hcount_t rx, input vcount_t ry,
                                        input logic en);
    logic blank;
    rgb_t c;
    blank = (h >= HBLKSTART) || (v >= VBLKSTART);
    if (blank) c = COLOR_BLANK;
    else if (h == 0 || h == HBLKSTART - 1 || v == 0 || v == VBLKSTART - 1) c = COLOR_BORDER;
    else if (v < VBLKSTART / 2) c = COLOR_TOP;
    else c = COLOR_BOTTOM;
    if (en && !blank && int'(h) >= int'(rx) && int'(h) < int'(rx) + int'(RECT_W) &&
        int'(v) >= int'(ry) && int'(v) < int'(ry) + int'(RECT_H)) begin
      c = COLOR_RECT;
    end
    return c;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // model and stimulus, both on the rising edge.
  always @(posedge clk) begin
    checking <= 1'b1;
    if (rst) begin
      m_h     <= '0;
      m_v     <= '0;
      d1_h    <= '0;
      d1_v    <= '0;
      d2_h    <= '0;
      d2_v    <= '0;
      v1      <= 1'b0;
      exp_rgb <= COLOR_BLANK;
      m_rx    <= '0;
      m_ry    <= '0;
      m_en    <= 1'b0;
    end else begin
      cycles <= cycles + 1;
      if (m_h == HTOTAL - 11'd1) begin
        m_h <= '0;
        if (m_v == VTOTAL - 11'd1) begin
          m_v     <= '0;
          m_frame <= m_frame + 1;
        end else begin
          m_v <= m_v + 11'd1;
        end
      end else begin
        m_h <= m_h + 11'd1;
      end
      d1_h    <= m_h;
      d1_v    <= m_v;
      v1      <= 1'b1;
      d2_h    <= d1_h;
      d2_v    <= d1_v;
      exp_rgb <= v1 ? pixel_colour(d1_h, d1_v, m_rx, m_ry, m_en) : COLOR_BLANK;
      if (m_h == '0 && m_v == VBLKSTART) begin  // start of vertical blanking.
        m_rx <= xpos;
        m_ry <= ypos;
        m_en <= 1'b1;
      end
      if (m_frame == 0 && m_h == HTOTAL - 11'd1 && m_v == VBLKSTART - 11'd1) begin
        xpos <= 11'(EDGE_X);  // lands one cycle before the latch.
        ypos <= 11'(EDGE_Y);
      end else if (m_frame == 0 && m_h == '0 && m_v == VBLKSTART) begin
        xpos <= 11'd100;  // too late for this frame.
        ypos <= 11'd100;
      end else if (cycles >= next_change) begin
        seed = lcg_next(seed);
        xpos <= 11'((seed >> 8) % 32'd832);
        seed = lcg_next(seed);
        ypos <= 11'((seed >> 8) % 32'd620);
        seed = lcg_next(seed);
        next_change <= cycles + 2000 + int'((seed >> 8) % 32'd4000);
      end
    end
  end

  // outputs are stable on the falling edge.
  always @(negedge clk) begin
    if (checking) begin
      compare("hcount", 32'(hcount), 32'(d2_h));
      compare("vcount", 32'(vcount), 32'(d2_v));
      compare("hblnk", 32'(hblnk), 32'(d2_h >= HBLKSTART));
      compare("hsync", 32'(hsync), 32'((d2_h >= HSYNCSTART) && (d2_h < HSYNCSTART + HSYNCTIME)));
      compare("vblnk", 32'(vblnk), 32'(d2_v >= VBLKSTART));
      compare("vsync", 32'(vsync), 32'((d2_v >= VSYNCSTART) && (d2_v < VSYNCSTART + VSYNCTIME)));
      compare("rgb", 32'(rgb), 32'(exp_rgb));
      if (rgb == COLOR_RECT && cycles < 2 * FRAME) orange++;
      if (cycles == 2 * FRAME) compare("orange pixels", 32'(orange), 32'(ORANGE_EXP));
    end
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (cycles < RUN_CYCLES) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    while (cycles < TIMEOUT) @(posedge clk);
    $display("run did not finish within %0d cycles", TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
